// ==== hsp_cfg.svh ====
`ifndef HSP_CFG_SVH
`define HSP_CFG_SVH

// OBI data and address width
`define HSP_WORD_WIDTH 32

// One pixel channel, two per word
`define HSP_PIXEL_WIDTH 16

// Low address bits kept before the modulo
`define HSP_VALUE_MASK 16'hFFFF

// Moduli for the two synthetic pixel channels
`define HSP_MOD_LSB 13    // Lower pixel
`define HSP_MOD_MSB 17    // Upper pixel

// Burst length counter, up to 1023 pixels
`define HSP_COUNT_WIDTH 10

// Channel sum width, wraps on overflow
`define HSP_SUM_WIDTH 24

// Grant LFSR reset value, must not be zero
`define HSP_LFSR_SEED 16'hACE1

`endif

// ==== hsp_pkg.sv ====
`default_nettype none

`include "hsp_cfg.svh"

package hsp_pkg;

  // Read data word as returned by the responder
  typedef logic [`HSP_WORD_WIDTH-1:0] word_t;

  // Word address, same width as the data bus
  typedef logic [`HSP_WORD_WIDTH-1:0] addr_t;

  typedef logic [`HSP_PIXEL_WIDTH-1:0] pixel_t;   // One channel
  typedef logic [`HSP_COUNT_WIDTH-1:0] count_t;   // Pixels per burst
  typedef logic [`HSP_SUM_WIDTH-1:0]   sum_t;     // Per-channel accumulator

  // Fetch sequencer states
  typedef enum logic [1:0] {
    IDLE = 2'd0,   // Waiting for start
    REQ  = 2'd1,   // Request held until granted
    WAIT = 2'd2,   // Read data returns here
    DONE = 2'd3    // One-cycle end marker
  } fetch_state_t;

endpackage

`default_nettype wire

// ==== hsp_fetch_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module hsp_fetch_state (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start,        // Burst start pulse
  input  hsp_pkg::count_t pixel_count,  // Sampled only to catch empty bursts
  input  logic            last,         // Counter is on its final pixel
  input  logic            obi_gnt,
  input  logic            obi_rvalid,
  output logic            load,         // Capture base and count
  output logic            step,         // Advance to next word
  output logic            obi_req,
  output logic            clear,        // Zero the sums
  output logic            sample,       // Accumulate current rdata
  output logic            busy,
  output logic            done
);

  hsp_pkg::fetch_state_t state, state_nxt;

  logic start_ok;   // Start seen while idle
  logic accepted;   // Read accepted at this edge

  assign start_ok = start && (state == hsp_pkg::IDLE);
  assign accepted = obi_req && obi_gnt;

  // Counter load and sum clear share the accepted start
  assign load  = start_ok;
  assign clear = start_ok;

  assign obi_req = (state == hsp_pkg::REQ);   // Dropped right after acceptance

  // Responder returns data one cycle after the grant, so WAIT sees it at once
  assign sample = (state == hsp_pkg::WAIT) && obi_rvalid;
  assign step   = sample;

  assign busy = (state != hsp_pkg::IDLE);
  assign done = (state == hsp_pkg::DONE);

  always_comb begin
    state_nxt = state;
    case (state)
      hsp_pkg::IDLE: begin
        if (start) begin
          // Empty burst skips the bus entirely
          state_nxt = (pixel_count == '0) ? hsp_pkg::DONE : hsp_pkg::REQ;
        end
      end
      hsp_pkg::REQ: begin
        if (accepted) state_nxt = hsp_pkg::WAIT;   // Stay here while gnt is withheld
      end
      hsp_pkg::WAIT: begin
        if (obi_rvalid) begin
          state_nxt = last ? hsp_pkg::DONE : hsp_pkg::REQ;
        end
      end
      hsp_pkg::DONE: state_nxt = hsp_pkg::IDLE;
      default:       state_nxt = hsp_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= hsp_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== hsp_addr_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module hsp_addr_counter (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            load,          // Start of burst
  input  logic            step,          // One pixel consumed
  input  hsp_pkg::addr_t  base_addr,
  input  hsp_pkg::count_t pixel_count,
  output hsp_pkg::addr_t  addr,          // Current word address
  output logic            last           // Final pixel of the burst
);

  hsp_pkg::addr_t  addr_q;
  hsp_pkg::count_t remaining;   // Pixels still to fetch, current one included

  // Word addressing, one pixel pair per address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (load) begin
      addr_q <= base_addr;
    end else if (step) begin
      addr_q <= addr_q + hsp_pkg::addr_t'(1);   // Wraps at the top of the space
    end
  end

  // Remaining count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      remaining <= '0;
    end else if (load) begin
      remaining <= pixel_count;
    end else if (step && (remaining != '0)) begin
      remaining <= remaining - hsp_pkg::count_t'(1);   // Never underflows
    end
  end

  assign addr = addr_q;

  // Sequencer reads this in WAIT, before the step lands
  assign last = (remaining == hsp_pkg::count_t'(1));

endmodule

`default_nettype wire

// ==== hsp_obi_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "hsp_cfg.svh"

module hsp_obi_mem (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           obi_req,
  input  hsp_pkg::addr_t obi_addr,
  input  logic           def_gnt,      // Grant driven while idle
  input  logic           random_gnt,   // Pseudo-random grant under request
  output logic           obi_gnt,
  output logic           obi_rvalid,
  output hsp_pkg::word_t obi_rdata
);

  logic [15:0]     lfsr;
  logic            lfsr_fb;
  hsp_pkg::pixel_t masked;      // Low address bits after the mask
  hsp_pkg::pixel_t lsb_pixel;
  hsp_pkg::pixel_t msb_pixel;

  // x^16 + x^14 + x^13 + x^11 + 1, maximal length
  assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr <= `HSP_LFSR_SEED;
    end else begin
      lfsr <= {lfsr[14:0], lfsr_fb};   // Free-running, not tied to requests
    end
  end

  // No storage behind the port, data comes from the address itself
  assign masked    = obi_addr[`HSP_PIXEL_WIDTH-1:0] & `HSP_VALUE_MASK;
  assign lsb_pixel = masked % hsp_pkg::pixel_t'(`HSP_MOD_LSB);
  assign msb_pixel = masked % hsp_pkg::pixel_t'(`HSP_MOD_MSB);

  // Registered grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      obi_gnt <= 1'b0;
    end else if (obi_req) begin
      obi_gnt <= random_gnt ? lfsr[0] : 1'b1;
    end else begin
      obi_gnt <= def_gnt;
    end
  end

  // Response valid for exactly one cycle after each accepting edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      obi_rvalid <= 1'b0;
    end else begin
      obi_rvalid <= obi_req && obi_gnt;
    end
  end

  // Read data only meaningful with rvalid
  always_ff @(posedge clk) begin
    if (obi_req && obi_gnt) begin
      obi_rdata <= {msb_pixel, lsb_pixel};   // Upper pixel over lower pixel
    end
  end

endmodule

`default_nettype wire

// ==== hsp_pixel_accum.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "hsp_cfg.svh"

module hsp_pixel_accum (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           clear,     // Start of a new burst
  input  logic           sample,    // rdata holds a valid word
  input  hsp_pkg::word_t rdata,
  output hsp_pkg::sum_t  lsb_sum,
  output hsp_pkg::sum_t  msb_sum
);

  hsp_pkg::pixel_t lsb_pixel;
  hsp_pkg::pixel_t msb_pixel;

  // Word layout is upper pixel over lower pixel
  assign lsb_pixel = rdata[`HSP_PIXEL_WIDTH-1:0];
  assign msb_pixel = rdata[`HSP_WORD_WIDTH-1:`HSP_PIXEL_WIDTH];

  // Lower channel
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsb_sum <= '0;
    end else if (clear) begin
      lsb_sum <= '0;
    end else if (sample) begin
      lsb_sum <= lsb_sum + hsp_pkg::sum_t'(lsb_pixel);   // Wraps at sum width
    end
  end

  // Upper channel
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      msb_sum <= '0;
    end else if (clear) begin
      msb_sum <= '0;
    end else if (sample) begin
      msb_sum <= msb_sum + hsp_pkg::sum_t'(msb_pixel);
    end
  end

  // Both sums hold after the burst until the next clear

endmodule

`default_nettype wire

// ==== hsp_fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module hsp_fetch_top (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start,
  input  hsp_pkg::addr_t  base_addr,
  input  hsp_pkg::count_t pixel_count,
  input  logic            def_gnt,      // Grant level while no request
  input  logic            random_gnt,   // LFSR-driven grant when set
  output logic            busy,
  output logic            done,
  output hsp_pkg::sum_t   lsb_sum,
  output hsp_pkg::sum_t   msb_sum
);

  // Sequencer to counter
  logic load;
  logic step;
  logic last;

  // OBI between sequencer and responder
  hsp_pkg::addr_t obi_addr;   // Straight from the counter
  logic           obi_req;
  logic           obi_gnt;
  logic           obi_rvalid;
  hsp_pkg::word_t obi_rdata;

  // Sequencer to accumulator
  logic clear;
  logic sample;

  hsp_fetch_state i_hsp_fetch_state (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .pixel_count (pixel_count),
    .last        (last),
    .obi_gnt     (obi_gnt),
    .obi_rvalid  (obi_rvalid),
    .load        (load),
    .step        (step),
    .obi_req     (obi_req),
    .clear       (clear),
    .sample      (sample),
    .busy        (busy),
    .done        (done)
  );

  hsp_addr_counter i_hsp_addr_counter (
    .clk         (clk),
    .rst_n       (rst_n),
    .load        (load),
    .step        (step),
    .base_addr   (base_addr),
    .pixel_count (pixel_count),
    .addr        (obi_addr),
    .last        (last)
  );

  hsp_obi_mem i_hsp_obi_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .obi_req    (obi_req),
    .obi_addr   (obi_addr),
    .def_gnt    (def_gnt),
    .random_gnt (random_gnt),
    .obi_gnt    (obi_gnt),
    .obi_rvalid (obi_rvalid),
    .obi_rdata  (obi_rdata)
  );

  hsp_pixel_accum i_hsp_pixel_accum (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear   (clear),
    .sample  (sample),
    .rdata   (obi_rdata),
    .lsb_sum (lsb_sum),
    .msb_sum (msb_sum)
  );

endmodule

`default_nettype wire

// ==== tb_hsp_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_hsp_fetch;

  logic            clk;
  logic            rst_n;
  logic            start;
  hsp_pkg::addr_t  base_addr;
  hsp_pkg::count_t pixel_count;
  logic            def_gnt;
  logic            random_gnt;
  logic            busy;
  logic            done;
  hsp_pkg::sum_t   lsb_sum;
  hsp_pkg::sum_t   msb_sum;

  int error_count;
  int timeout_count;
  int burst_idx;       // Current line of the stimulus file, data lines only
  bit hung;            // A burst never reached done

  hsp_fetch_top i_hsp_fetch_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .base_addr   (base_addr),
    .pixel_count (pixel_count),
    .def_gnt     (def_gnt),
    .random_gnt  (random_gnt),
    .busy        (busy),
    .done        (done),
    .lsb_sum     (lsb_sum),
    .msb_sum     (msb_sum)
  );

  always #50 clk = ~clk;   // 100 ns period

  task automatic check_sum(input string name, input hsp_pkg::sum_t exp,
                           input hsp_pkg::sum_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      error_count++;
    end
  endtask

  // Outputs settle at the edge, so sampling and driving both happen 10 ns later
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic run_burst(input hsp_pkg::addr_t base, input hsp_pkg::count_t count,
                           input logic dg, input logic rg,
                           input hsp_pkg::sum_t exp_lsb, input hsp_pkg::sum_t exp_msb);
    int cycles;
    int limit;
    int done_count;
    int gap;
    limit      = 100 + 20 * count;   // Generous for LFSR grant stalls
    cycles     = 0;
    done_count = 0;
    def_gnt     = dg;
    random_gnt  = rg;
    base_addr   = base;
    pixel_count = count;
    start       = 1'b1;
    next_cycle();                     // Start taken at this edge
    while (done_count == 0 && cycles < limit) begin
      check_flag("busy", 1'b1, busy); // High through the done cycle
      if (done) begin
        done_count++;
        check_sum("lsb_sum", exp_lsb, lsb_sum);
        check_sum("msb_sum", exp_msb, msb_sum);
      end
      if (cycles == 0) begin
        start       = 1'b1;           // Second start, lands while busy
        base_addr   = base + 32'h40;
        pixel_count = hsp_pkg::count_t'(count + 3);
      end else begin
        start = 1'b0;
      end
      cycles++;
      next_cycle();
    end
    start = 1'b0;                     // Before the next edge, even for empty bursts
    if (done_count == 0) begin
      $display("Burst %0d hung: done never came within %0d cycles", burst_idx, limit);
      timeout_count++;
      hung = 1'b1;
    end else begin
      check_flag("done", 1'b0, done); // Pulse lasts one cycle
      check_flag("busy", 1'b0, busy);
      gap = 1 + ($urandom % 4);
      repeat (gap) begin
        next_cycle();
        check_flag("done", 1'b0, done); // Ignored start gives no second done
        check_flag("busy", 1'b0, busy);
      end
      check_sum("lsb_sum", exp_lsb, lsb_sum);   // Held until next start
      check_sum("msb_sum", exp_msb, msb_sum);
    end
  endtask

  initial begin : main
    int               fd;
    int               code;
    int unsigned      seed_val;
    logic [8*128-1:0] line_buf;
    logic [31:0]      base_v;
    int               cnt_v;
    int               dg_v;
    int               rg_v;
    int               lsb_v;
    int               msb_v;
    seed_val      = $urandom(32'hff6dcfc4);
    error_count   = 0;
    timeout_count = 0;
    burst_idx     = 0;
    hung          = 1'b0;
    clk           = 1'b0;
    rst_n         = 1'b0;
    start         = 1'b0;
    base_addr     = '0;
    pixel_count   = '0;
    def_gnt       = 1'b0;
    random_gnt    = 1'b0;
    repeat (5) @(posedge clk);
    #10;
    rst_n = 1'b1;
    next_cycle();
    // Idle after reset
    check_flag("busy", 1'b0, busy);
    check_flag("done", 1'b0, done);
    check_sum("lsb_sum", '0, lsb_sum);
    check_sum("msb_sum", '0, msb_sum);
    fd = $fopen("hsp_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open hsp_stimulus.txt for reading");
      error_count++;
    end else begin
      while (!$feof(fd) && !hung) begin
        code = $fgets(line_buf, fd);
        // Comment and blank lines fail the scan and are skipped
        if (code != 0 && $sscanf(line_buf, "%h %d %d %d %d %d",
                                 base_v, cnt_v, dg_v, rg_v, lsb_v, msb_v) == 6) begin
          burst_idx++;
          run_burst(base_v, hsp_pkg::count_t'(cnt_v), dg_v[0], rg_v[0],
                    hsp_pkg::sum_t'(lsb_v), hsp_pkg::sum_t'(msb_v));
        end
      end
      $fclose(fd);
      if (burst_idx == 0) begin
        $display("No bursts found in hsp_stimulus.txt");
        error_count++;
      end
    end
    $display("Run complete: %0d bursts, %0d errors, %0d timeouts",
             burst_idx, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hsp_stimulus.txt ====
# base_hex count def_gnt random_gnt exp_lsb_sum exp_msb_sum
# Sums are masked address mod 13 and mod 17 over the burst words, decimal
00000000 0 1 0 0 0
00000000 1 1 0 0 0
00000000 20 1 0 99 139
00000000 20 0 0 99 139
00000000 20 0 1 99 139
00000000 20 1 1 99 139
00000100 8 1 0 48 36
00000100 8 0 1 48 36
0000FFFC 8 1 0 21 51
0000FFFC 8 1 1 21 51
1234FFF0 24 0 1 109 163
00000064 40 1 1 243 309
0000ABCD 5 0 0 20 20
00005555 0 0 1 0 0

// ==== project.f ====
+incdir+.
hsp_pkg.sv
hsp_fetch_fsm.sv
hsp_addr_counter.sv
hsp_obi_mem.sv
hsp_pixel_accum.sv
hsp_fetch_top.sv
tb_hsp_fetch.sv

// ==== Bender.yml ====
package:
  name: hsp_fetch

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - hsp_pkg.sv
      - hsp_fetch_fsm.sv
      - hsp_addr_counter.sv
      - hsp_obi_mem.sv
      - hsp_pixel_accum.sv
      - hsp_fetch_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_hsp_fetch.sv
